//--- flist.f
verilog/mem_pkg.sv
verilog/mem_stage.sv
verilog/data_cache.sv
verilog/mem_subsystem.sv
testbench/tb_mem_model.sv
testbench/tb_mem_subsystem.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the memory subsystem testbench with Verilator and runs it.
set -u
cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --timescale 1ns/1ps --top-module tb_mem_subsystem \
	-f flist.f --Mdir "$build_dir" -o sim_mem
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./$build_dir/sim_mem" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if grep -qx "RESULT: PASS" "$log_file"; then
	exit 0
fi
echo "Pass message not found in $log_file"
exit 1

//--- testbench/tb_mem_model.sv
`timescale 1ns/1ps

module tb_mem_model #(
	parameter mem_pkg::word_t PATTERN = 64'h0
) (
	input logic clk,
	input logic reset,
	input logic mem_req,
	input logic mem_we,
	input mem_pkg::addr_t mem_addr,
	input mem_pkg::word_t mem_wdata,
	output mem_pkg::word_t mem_rdata,
	output logic mem_ack,
	output int wr_count,
	output int rd_count,
	output mem_pkg::addr_t last_wr_addr,
	output mem_pkg::word_t last_wr_data
);
	import mem_pkg::*;

	word_t words [addr_t];	// Holds only the words written so far.
	logic ack_q = 1'b0;
	word_t rdata_q = '0;
	int wr_count_q = 0;
	int rd_count_q = 0;
	addr_t last_addr_q = '0;
	word_t last_data_q = '0;
	logic busy = 1'b0;
	logic cur_we;
	addr_t cur_addr;
	word_t cur_wdata;
	int unsigned wait_cycles;

	assign mem_ack = ack_q;
	assign mem_rdata = rdata_q;
	assign wr_count = wr_count_q;
	assign rd_count = rd_count_q;
	assign last_wr_addr = last_addr_q;
	assign last_wr_data = last_data_q;

	// Untouched words read back as their address XORed with the pattern.
	function automatic word_t read_word(input addr_t addr);
		if (words.exists(addr))
			return words[addr];
		return addr ^ PATTERN;
	endfunction

	always @(posedge clk) begin
		ack_q <= 1'b0;
		if (reset) begin
			busy <= 1'b0;
		end else if (busy) begin
			if (wait_cycles == 0) begin
				if (cur_we)
					words[cur_addr] = cur_wdata;
				else
					rdata_q <= read_word(cur_addr);
				ack_q <= 1'b1;
				busy <= 1'b0;
			end else begin
				wait_cycles <= wait_cycles - 1;
			end
		end else if (mem_req) begin
			busy <= 1'b1;
			cur_we <= mem_we;
			cur_addr <= mem_addr;
			cur_wdata <= mem_wdata;
			wait_cycles <= $urandom % 4;	// Up to three extra cycles of latency.
			if (mem_we) begin
				wr_count_q <= wr_count_q + 1;
				last_addr_q <= mem_addr;
				last_data_q <= mem_wdata;
			end else begin
				rd_count_q <= rd_count_q + 1;
			end
		end
	end

endmodule

//--- testbench/tb_mem_subsystem.sv
`timescale 1ns/1ps

module tb_mem_subsystem;
	import mem_pkg::*;

	localparam int TIMEOUT = 200;
	localparam int DRIVE_DELAY = 1;
	localparam int RANDOM_SEED = 55;
	localparam word_t PATTERN = 64'hc3a5_0f1e_96d2_7b48;
	localparam opcode_t opcode_add = 10'h001;
	localparam opcode_t opcode_mov = 10'h08b;

	logic clk = 1'b0;
	logic reset;
	logic enable;
	opcode_t opcode;
	oprd_type_t oprd1_type;
	oprd_type_t oprd2_type;
	addr_t oprd1_ext;
	addr_t oprd1_value;
	addr_t oprd2_ext;
	addr_t oprd2_value;
	result_t alu_result;
	logic mem_blocked;
	logic mem_wb;
	result_t mem_result;
	logic mem_req;
	logic mem_we;
	addr_t mem_addr;
	word_t mem_wdata;
	word_t mem_rdata;
	logic mem_ack;
	int wr_count;
	int rd_count;
	addr_t last_wr_addr;
	word_t last_wr_data;

	always #2 clk = ~clk;	// 4 ns period.

	mem_subsystem #(
		.INDEX_BITS(4)
	) u_mem_subsystem (
		.clk(clk),
		.reset(reset),
		.enable(enable),
		.opcode(opcode),
		.oprd1_type(oprd1_type),
		.oprd2_type(oprd2_type),
		.oprd1_ext(oprd1_ext),
		.oprd1_value(oprd1_value),
		.oprd2_ext(oprd2_ext),
		.oprd2_value(oprd2_value),
		.alu_result(alu_result),
		.mem_blocked(mem_blocked),
		.mem_wb(mem_wb),
		.mem_result(mem_result),
		.mem_req(mem_req),
		.mem_we(mem_we),
		.mem_addr(mem_addr),
		.mem_wdata(mem_wdata),
		.mem_rdata(mem_rdata),
		.mem_ack(mem_ack)
	);

	tb_mem_model #(
		.PATTERN(PATTERN)
	) u_mem_model (
		.clk(clk),
		.reset(reset),
		.mem_req(mem_req),
		.mem_we(mem_we),
		.mem_addr(mem_addr),
		.mem_wdata(mem_wdata),
		.mem_rdata(mem_rdata),
		.mem_ack(mem_ack),
		.wr_count(wr_count),
		.rd_count(rd_count),
		.last_wr_addr(last_wr_addr),
		.last_wr_data(last_wr_data)
	);

	task automatic stop_with_failure(input string reason);
		$display("%s", reason);
		$display("RESULT: FAIL");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_result(input string name, input result_t got, input result_t exp);
		if (got !== exp)
			stop_with_failure($sformatf("FAIL t=%0t %s got=%h expected=%h", $time, name, got, exp));
	endtask

	task automatic check_word(input string name, input word_t got, input word_t exp);
		if (got !== exp)
			stop_with_failure($sformatf("FAIL t=%0t %s got=%h expected=%h", $time, name, got, exp));
	endtask

	task automatic check_addr(input string name, input addr_t got, input addr_t exp);
		if (got !== exp)
			stop_with_failure($sformatf("FAIL t=%0t %s got=%h expected=%h", $time, name, got, exp));
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		if (got != exp)
			stop_with_failure($sformatf("FAIL t=%0t %s got=%0d expected=%0d", $time, name, got, exp));
	endtask

	// Presents one micro-op and returns once mem_wb is seen; latency counts edges from the drive.
	task automatic run_op(input opcode_t op, input oprd_type_t type1, input oprd_type_t type2,
			input addr_t ext1, input addr_t val1, input addr_t ext2, input addr_t val2,
			input result_t alu, output int latency, output logic blocked_seen);
		logic accepted;
		accepted = 1'b0;
		latency = 0;
		blocked_seen = 1'b0;
		opcode = op;
		oprd1_type = type1;
		oprd2_type = type2;
		oprd1_ext = ext1;
		oprd1_value = val1;
		oprd2_ext = ext2;
		oprd2_value = val2;
		alu_result = alu;
		enable = 1'b1;
		while (!accepted) begin
			@(negedge clk);
			accepted = !mem_blocked;	// The next edge consumes the micro-op.
			blocked_seen = blocked_seen | mem_blocked;
			@(posedge clk);
			latency++;
			if (latency > TIMEOUT)
				stop_with_failure("Timeout: the stage never accepted the micro-op.");
		end
		#DRIVE_DELAY;
		enable = 1'b0;
		while (!mem_wb) begin
			@(posedge clk);
			#DRIVE_DELAY;
			latency++;
			if (latency > TIMEOUT)
				stop_with_failure("Timeout: mem_wb never arrived.");
		end
	endtask

	task automatic load_word(input addr_t addr, output int latency);
		logic blocked;
		run_op(opcode_mov, oprd_reg, oprd_mem, '0, '0, addr, '0, '0, latency, blocked);
	endtask

	task automatic store_word(input addr_t addr, input word_t data);
		int latency;
		logic blocked;
		run_op(opcode_mov, oprd_mem, oprd_reg, addr, '0, '0, '0, {~data, data}, latency, blocked);
		check_result("store mem_result", mem_result, '0);
	endtask

	task automatic test_pass_through_lea();
		int latency;
		logic blocked;
		run_op(opcode_add, oprd_reg, oprd_imm, 64'h11, 64'h22, 64'h33, 64'h44,
			128'h0123_4567_89ab_cdef_fedc_ba98_7654_3210, latency, blocked);
		check_result("pass mem_result", mem_result, 128'h0123_4567_89ab_cdef_fedc_ba98_7654_3210);
		check_count("pass latency", latency, 1);
		check_count("pass mem_blocked", int'(blocked), 0);
		run_op(opcode_lea, oprd_reg, oprd_mem, 64'h9999, 64'h1, 64'h1234_0000, 64'h5678,
			128'hffff, latency, blocked);
		check_result("lea mem_result", mem_result, {64'd0, 64'h1234_5678});
		check_count("lea latency", latency, 1);
		check_count("lea mem_blocked", int'(blocked), 0);
	endtask

	task automatic test_read_miss_hit();
		addr_t addr;
		int reads;
		int writes;
		int latency;
		addr = 64'h1040;
		reads = rd_count;
		writes = wr_count;
		load_word(addr, latency);
		check_result("miss mem_result", mem_result, {64'd0, addr ^ PATTERN});
		check_count("miss memory reads", rd_count, reads + 1);
		load_word(addr, latency);
		check_result("hit mem_result", mem_result, {64'd0, addr ^ PATTERN});
		check_count("hit memory reads", rd_count, reads + 1);
		check_count("hit memory writes", wr_count, writes);
		check_count("hit latency", latency, 3);	// Request, done, then mem_wb.
	endtask

	task automatic test_store_load();
		int writes;
		int latency;
		writes = wr_count;
		store_word(64'h2010, 64'hbeef_0000_cafe_0001);
		load_word(64'h2010, latency);
		check_result("load after store", mem_result, {64'd0, 64'hbeef_0000_cafe_0001});
		check_count("write-back memory writes", wr_count, writes);
	endtask

	task automatic test_stack_push_pop();
		addr_t sp;
		int latency;
		logic blocked;
		sp = 64'h8000;
		run_op(opcode_add, oprd_stack, oprd_reg, sp, '0, '0, '0,
			{64'h5555, 64'h7777_1111_2222_3333}, latency, blocked);
		check_result("push mem_result", mem_result, '0);
		run_op(opcode_mov, oprd_reg, oprd_stack, '0, '0, sp - 64'd8, '0, '0, latency, blocked);
		check_result("pop mem_result", mem_result, {64'd0, 64'h7777_1111_2222_3333});
		load_word(sp - 64'd8, latency);	// The pushed word sits below the old stack pointer.
		check_result("pushed word", mem_result, {64'd0, 64'h7777_1111_2222_3333});
	endtask

	task automatic test_eviction();
		int writes;
		int latency;
		writes = wr_count;
		store_word(64'h3018, 64'h0a0b_0c0d_0e0f_1011);
		load_word(64'h5018, latency);	// Same index, different tag.
		check_result("conflict load", mem_result, {64'd0, 64'h5018 ^ PATTERN});
		check_count("eviction memory writes", wr_count, writes + 1);
		check_addr("eviction mem_addr", last_wr_addr, 64'h3018);
		check_word("eviction mem_wdata", last_wr_data, 64'h0a0b_0c0d_0e0f_1011);
		load_word(64'h3018, latency);
		check_result("reload after eviction", mem_result, {64'd0, 64'h0a0b_0c0d_0e0f_1011});
	endtask

	task automatic test_clflush();
		int writes;
		int reads;
		int latency;
		logic blocked;
		store_word(64'h4028, 64'hd00d_f00d_1234_abcd);
		writes = wr_count;
		run_op(opcode_clflush, oprd_reg, oprd_mem, '0, '0, 64'h4028, '0, '0, latency, blocked);
		check_result("flush mem_result", mem_result, '0);
		check_count("flush memory writes", wr_count, writes + 1);
		check_addr("flush mem_addr", last_wr_addr, 64'h4028);
		check_word("flush mem_wdata", last_wr_data, 64'hd00d_f00d_1234_abcd);
		run_op(opcode_clflush, oprd_reg, oprd_mem, '0, '0, 64'h4028, '0, '0, latency, blocked);
		check_count("second flush memory writes", wr_count, writes + 1);
		reads = rd_count;
		load_word(64'h4028, latency);
		check_result("load after flush", mem_result, {64'd0, 64'hd00d_f00d_1234_abcd});
		check_count("load after flush memory reads", rd_count, reads + 1);
	endtask

	initial begin
		void'($urandom(RANDOM_SEED));
		reset = 1'b1;
		enable = 1'b0;
		opcode = '0;
		oprd1_type = oprd_reg;
		oprd2_type = oprd_reg;
		oprd1_ext = '0;
		oprd1_value = '0;
		oprd2_ext = '0;
		oprd2_value = '0;
		alu_result = '0;
		repeat (8) @(posedge clk);
		#DRIVE_DELAY;
		reset = 1'b0;
		if (mem_wb !== 1'b0 || mem_req !== 1'b0)
			stop_with_failure("Strobes are not low after reset.");
		@(posedge clk);
		#DRIVE_DELAY;
		test_pass_through_lea();
		test_read_miss_hit();
		test_store_load();
		test_stack_push_pop();
		test_eviction();
		test_clflush();
		$display("RESULT: PASS");
		$finish;
	end

endmodule

//--- verilog/data_cache.sv
`timescale 1ns/1ps

module data_cache #(
	parameter int INDEX_BITS = 4
) (
	input logic clk,
	input logic reset,
	input logic dcache_en,
	input logic dcache_wren,
	input logic dcache_flush,
	input mem_pkg::addr_t dcache_addr,
	input mem_pkg::word_t dcache_wdata,
	output mem_pkg::word_t dcache_rdata,
	output logic dcache_done,
	output logic mem_req,
	output logic mem_we,
	output mem_pkg::addr_t mem_addr,
	output mem_pkg::word_t mem_wdata,
	input mem_pkg::word_t mem_rdata,
	input logic mem_ack
);
	import mem_pkg::*;

	localparam int LINES = 1 << INDEX_BITS;
	localparam int TAG_BITS = 61 - INDEX_BITS;	// Bits 2:0 select a byte and are ignored.

	typedef enum logic [1:0] {
		cache_idle,
		cache_lookup,
		cache_writeback,
		cache_fill
	} cache_state_t;

	cache_state_t state;

	logic [TAG_BITS-1:0] tag_mem [LINES];
	word_t data_mem [LINES];
	logic [LINES-1:0] valid;
	logic [LINES-1:0] dirty;

	// Request held while a miss or a writeback is in progress.
	addr_t req_addr;
	word_t req_wdata;
	logic req_wren;
	logic req_flush;

	logic [INDEX_BITS-1:0] in_index;
	logic [TAG_BITS-1:0] in_tag;
	logic in_hit;
	logic [INDEX_BITS-1:0] req_index;
	logic [TAG_BITS-1:0] req_tag;
	logic victim_dirty;

	assign in_index = dcache_addr[3 +: INDEX_BITS];
	assign in_tag = dcache_addr[63 -: TAG_BITS];
	assign in_hit = valid[in_index] && (tag_mem[in_index] == in_tag);

	assign req_index = req_addr[3 +: INDEX_BITS];
	assign req_tag = req_addr[63 -: TAG_BITS];
	assign victim_dirty = valid[req_index] && dirty[req_index];

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= cache_idle;
			valid <= '0;
			dirty <= '0;
			dcache_done <= 1'b0;
			mem_req <= 1'b0;
		end else begin
			dcache_done <= 1'b0;
			mem_req <= 1'b0;
			case (state)
				cache_idle: begin
					if (dcache_en) begin
						req_addr <= dcache_addr;
						req_wdata <= dcache_wdata;
						req_wren <= dcache_wren;
						req_flush <= dcache_flush;
						if (dcache_flush) begin
							if (in_hit && dirty[in_index]) begin
								mem_req <= 1'b1;	// Dirty line goes back before it is dropped.
								mem_we <= 1'b1;
								mem_addr <= {dcache_addr[63:3], 3'b000};
								mem_wdata <= data_mem[in_index];
								state <= cache_writeback;
							end else begin
								if (in_hit)
									valid[in_index] <= 1'b0;
								dcache_done <= 1'b1;
							end
						end else if (in_hit) begin
							if (dcache_wren) begin
								data_mem[in_index] <= dcache_wdata;
								dirty[in_index] <= 1'b1;
							end else begin
								dcache_rdata <= data_mem[in_index];
							end
							dcache_done <= 1'b1;
						end else begin
							state <= cache_lookup;
						end
					end
				end
				cache_lookup: begin
					if (victim_dirty) begin
						mem_req <= 1'b1;
						mem_we <= 1'b1;
						mem_addr <= {tag_mem[req_index], req_index, 3'b000};
						mem_wdata <= data_mem[req_index];
						state <= cache_writeback;
					end else if (req_wren) begin
						// The whole word is overwritten, so no fill is needed.
						tag_mem[req_index] <= req_tag;
						data_mem[req_index] <= req_wdata;
						valid[req_index] <= 1'b1;
						dirty[req_index] <= 1'b1;
						dcache_done <= 1'b1;
						state <= cache_idle;
					end else begin
						mem_req <= 1'b1;
						mem_we <= 1'b0;
						mem_addr <= {req_addr[63:3], 3'b000};
						state <= cache_fill;
					end
				end
				cache_writeback: begin
					if (mem_ack) begin
						valid[req_index] <= 1'b0;
						dirty[req_index] <= 1'b0;
						if (req_flush) begin
							dcache_done <= 1'b1;
							state <= cache_idle;
						end else begin
							state <= cache_lookup;	// Line is now free for the miss.
						end
					end
				end
				cache_fill: begin
					if (mem_ack) begin
						tag_mem[req_index] <= req_tag;
						data_mem[req_index] <= mem_rdata;
						valid[req_index] <= 1'b1;
						dirty[req_index] <= 1'b0;
						dcache_rdata <= mem_rdata;
						dcache_done <= 1'b1;
						state <= cache_idle;
					end
				end
			endcase
		end
	end

endmodule

//--- verilog/mem_pkg.sv
package mem_pkg;

	// Widths that carry a meaning across the memory stage and the data cache.
	typedef logic [63:0] addr_t;	// Byte address.
	typedef logic [63:0] word_t;	// One cache word.
	typedef logic [127:0] result_t;	// Stage result as handed to writeback.
	typedef logic [9:0] opcode_t;	// Decoded micro-op opcode.
	typedef logic [1:0] oprd_type_t;	// Operand kind.

	// Operand kinds, as set by the decoder.
	localparam oprd_type_t oprd_reg = 2'd0;	// Register operand.
	localparam oprd_type_t oprd_imm = 2'd1;	// Immediate operand.
	localparam oprd_type_t oprd_mem = 2'd2;	// Memory operand at ext plus value.
	localparam oprd_type_t oprd_stack = 2'd3;	// Stack operand whose ext holds the stack pointer.

	// Opcodes that the memory stage handles on its own.
	localparam opcode_t opcode_lea = 10'h08d;	// Load effective address.
	localparam opcode_t opcode_clflush = 10'h1ae;	// Flush one cache line.

endpackage

//--- verilog/mem_stage.sv
`timescale 1ns/1ps

module mem_stage (
	input logic clk,
	input logic reset,
	input logic enable,
	input mem_pkg::opcode_t opcode,
	input mem_pkg::oprd_type_t oprd1_type,
	input mem_pkg::oprd_type_t oprd2_type,
	input mem_pkg::addr_t oprd1_ext,
	input mem_pkg::addr_t oprd1_value,
	input mem_pkg::addr_t oprd2_ext,
	input mem_pkg::addr_t oprd2_value,
	input mem_pkg::result_t alu_result,
	input mem_pkg::word_t dcache_rdata,
	input logic dcache_done,
	output logic mem_blocked,
	output logic mem_wb,
	output mem_pkg::result_t mem_result,
	output logic dcache_en,
	output logic dcache_wren,
	output logic dcache_flush,
	output mem_pkg::addr_t dcache_addr,
	output mem_pkg::word_t dcache_wdata
);
	import mem_pkg::*;

	typedef enum logic {
		stage_idle,
		stage_waiting
	} stage_state_t;

	typedef enum logic [2:0] {
		op_none,
		op_lea,
		op_read,
		op_write,
		op_flush
	} mem_op_t;

	stage_state_t state;
	mem_op_t op;
	addr_t op_addr;
	addr_t oprd1_addr;
	addr_t oprd2_addr;
	logic is_mem_op;
	logic pending_read;

	assign oprd1_addr = oprd1_ext + oprd1_value;
	assign oprd2_addr = oprd2_ext + oprd2_value;

	// Pick the operation in priority order; the first match wins.
	always_comb begin
		op = op_none;
		op_addr = oprd2_addr;
		if (opcode == opcode_lea) begin
			op = op_lea;
		end else if (opcode == opcode_clflush) begin
			op = op_flush;
		end else if (oprd1_type == oprd_mem) begin
			op = op_write;	// Memory destination takes the ALU result.
			op_addr = oprd1_addr;
		end else if (oprd2_type == oprd_mem) begin
			op = op_read;
		end else if (oprd1_type == oprd_stack) begin
			op = op_write;	// Push goes below the current stack pointer.
			op_addr = oprd1_ext - 64'd8;
		end else if (oprd2_type == oprd_stack) begin
			op = op_read;	// Pop reads at the stack pointer itself.
			op_addr = oprd2_ext;
		end
	end

	assign is_mem_op = (op == op_read) || (op == op_write) || (op == op_flush);

	// Upstream stalls until the cache answers; released in the done cycle itself.
	assign mem_blocked = (state == stage_idle) ? (enable && is_mem_op) : !dcache_done;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= stage_idle;
			mem_wb <= 1'b0;
			dcache_en <= 1'b0;
			dcache_wren <= 1'b0;
			dcache_flush <= 1'b0;
		end else begin
			mem_wb <= 1'b0;	// All strobes are single-cycle pulses.
			dcache_en <= 1'b0;
			dcache_wren <= 1'b0;
			dcache_flush <= 1'b0;
			case (state)
				stage_idle: begin
					if (enable) begin
						if (is_mem_op) begin
							dcache_en <= 1'b1;
							dcache_wren <= (op == op_write);
							dcache_flush <= (op == op_flush);
							state <= stage_waiting;
						end else begin
							mem_wb <= 1'b1;	// LEA and pass-through finish at once.
						end
					end
				end
				stage_waiting: begin
					if (dcache_done) begin
						mem_wb <= 1'b1;
						state <= stage_idle;
					end
				end
			endcase
		end
	end

	// Request payload and result data.
	always_ff @(posedge clk) begin
		if (state == stage_idle && enable) begin
			dcache_addr <= op_addr;
			dcache_wdata <= alu_result[63:0];
			pending_read <= (op == op_read);
			if (op == op_lea)
				mem_result <= {64'd0, oprd2_addr};
			else if (op == op_none)
				mem_result <= alu_result;
		end
		if (state == stage_waiting && dcache_done)
			mem_result <= pending_read ? {64'd0, dcache_rdata} : '0;	// Stores and flushes give zero.
	end

endmodule

//--- verilog/mem_subsystem.sv
`timescale 1ns/1ps

module mem_subsystem #(
	parameter int INDEX_BITS = 4
) (
	input logic clk,
	input logic reset,
	input logic enable,
	input mem_pkg::opcode_t opcode,
	input mem_pkg::oprd_type_t oprd1_type,
	input mem_pkg::oprd_type_t oprd2_type,
	input mem_pkg::addr_t oprd1_ext,
	input mem_pkg::addr_t oprd1_value,
	input mem_pkg::addr_t oprd2_ext,
	input mem_pkg::addr_t oprd2_value,
	input mem_pkg::result_t alu_result,
	output logic mem_blocked,
	output logic mem_wb,
	output mem_pkg::result_t mem_result,
	output logic mem_req,
	output logic mem_we,
	output mem_pkg::addr_t mem_addr,
	output mem_pkg::word_t mem_wdata,
	input mem_pkg::word_t mem_rdata,
	input logic mem_ack
);
	import mem_pkg::*;

	// Stage to cache request and response.
	logic dcache_en;
	logic dcache_wren;
	logic dcache_flush;
	logic dcache_done;
	addr_t dcache_addr;
	word_t dcache_wdata;
	word_t dcache_rdata;

	mem_stage u_mem_stage (
		.clk(clk),
		.reset(reset),
		.enable(enable),
		.opcode(opcode),
		.oprd1_type(oprd1_type),
		.oprd2_type(oprd2_type),
		.oprd1_ext(oprd1_ext),
		.oprd1_value(oprd1_value),
		.oprd2_ext(oprd2_ext),
		.oprd2_value(oprd2_value),
		.alu_result(alu_result),
		.dcache_rdata(dcache_rdata),
		.dcache_done(dcache_done),
		.mem_blocked(mem_blocked),
		.mem_wb(mem_wb),
		.mem_result(mem_result),
		.dcache_en(dcache_en),
		.dcache_wren(dcache_wren),
		.dcache_flush(dcache_flush),
		.dcache_addr(dcache_addr),
		.dcache_wdata(dcache_wdata)
	);

	data_cache #(
		.INDEX_BITS(INDEX_BITS)
	) u_data_cache (
		.clk(clk),
		.reset(reset),
		.dcache_en(dcache_en),
		.dcache_wren(dcache_wren),
		.dcache_flush(dcache_flush),
		.dcache_addr(dcache_addr),
		.dcache_wdata(dcache_wdata),
		.dcache_rdata(dcache_rdata),
		.dcache_done(dcache_done),
		.mem_req(mem_req),
		.mem_we(mem_we),
		.mem_addr(mem_addr),
		.mem_wdata(mem_wdata),
		.mem_rdata(mem_rdata),
		.mem_ack(mem_ack)
	);

endmodule
